// ==== sources.f ====
src/sw_pkg.sv
src/sw_feed_if.sv
src/sw_score_if.sv
src/sw_seq_loader.sv
src/sw_cell.sv
src/sw_cell_array.sv
src/sw_max_tracker.sv
src/sw_top.sv
test/sw_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module sw_tb -f sources.f -o sw_sim
	./obj_dir/sw_sim 2>&1 | tee sim.log
	@! grep -q "TEST RESULT: FAIL" sim.log
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== test/sw_stimulus.txt ====
# columns: ref read (hex, 16 bases of 2 bits, base 0 in the top pair, A=0 C=1 G=2 T=3)
#          ref_len read_len expected_score expected_row expected_column (decimal)
# exact matches
1BE42D4E 1BE42D4E 16 16 16 15 15
1BE4A5C3 1BE45A3C  8  8  8  7  7
9A000000 B5555555  1  1  1  0  0
# read found inside the reference
1BE42D4E 42F19E37 16  5  5  4 10
1B1B1B1B 1B3C5A96 16  3  3  2  2
E4A73C96 4B8D21F0  4  3  2  1  3
# mismatches
1BE42D4E 1BE4ED4E 16 16 11 15 15
1BE42D4E 1B642C4E 16 16  6 10 10
4C3C3C3C 1E5A5A5A  2  2  1  1  0
# one inserted base in the read, then one in the reference
1BE42D4E 1BE4CB53 16 16  9 15 14
1BE4CB53 1BE42D4E 16 16  9 14 15
# two inserted bases, the gap path only ties the prefix
1BE42D4E 1BE7C2D4 14 16  7  6  6
# no match anywhere
00000000 FFFFFFFF 16 16  0  0  0
55555555 AAAAAAAA  7 10  0  0  0

// ==== test/sw_tb.sv ====
`default_nettype none

module sw_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import sw_pkg::*;

    localparam int    WAIT_LIMIT = 100;
    localparam string STIM_FILE  = "test/sw_stimulus.txt";

    logic   clk;
    logic   rst;
    logic   i_valid;
    seq_t   i_seq_ref;
    seq_t   i_seq_read;
    len_t   i_ref_len;
    len_t   i_read_len;
    logic   i_ready;
    logic   o_ready;
    logic   o_valid;
    score_t o_score;
    idx_t   o_row;
    idx_t   o_column;

    integer seed;
    int     errors;
    int     checks;
    int     jobs;
    bit     aborted;

    sw_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_valid),
        .i_seq_ref  (i_seq_ref),
        .i_seq_read (i_seq_read),
        .i_ref_len  (i_ref_len),
        .i_read_len (i_read_len),
        .o_ready    (o_ready),
        .i_ready    (i_ready),
        .o_valid    (o_valid),
        .o_score    (o_score),
        .o_row      (o_row),
        .o_column   (o_column)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input int got, input int expected);
        checks++;
        if (got != expected) begin
            errors++;
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
        end
    endtask

    // poll on falling edges until the DUT can take a job
    task automatic wait_for_ready();
        int n;
        n = 0;
        while (!o_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!o_ready) begin
            errors++;
            aborted = 1'b1;
            $display("Timeout at %0t ns: o_ready never went high", $time);
        end
    endtask

    task automatic run_job(input seq_t ref_w, input seq_t read_w, input int ref_len,
                           input int read_len, input int exp_score, input int exp_row,
                           input int exp_col);
        int gap;
        int hold;
        int lat;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(negedge clk);
        wait_for_ready();
        if (aborted) begin
            return;
        end
        i_valid    = 1'b1;
        i_seq_ref  = ref_w;
        i_seq_read = read_w;
        i_ref_len  = len_t'(ref_len);
        i_read_len = len_t'(read_len);
        @(negedge clk);
        // job taken on the edge just passed so the bus may change now
        i_valid    = 1'b0;
        i_seq_ref  = $random(seed);
        i_seq_read = $random(seed);
        lat = 0;
        while (!o_valid && lat < WAIT_LIMIT) begin
            if (o_ready) begin
                errors++;
                $display("Error at %0t ns: o_ready went high while a job was running", $time);
            end
            @(negedge clk);
            lat++;
        end
        if (!o_valid) begin
            errors++;
            aborted = 1'b1;
            $display("Timeout at %0t ns: no result for job %0d", $time, jobs);
            return;
        end
        check_value("latency", lat, ref_len + read_len + 2);
        check_value("o_score", o_score, exp_score);
        check_value("o_row", o_row, exp_row);
        check_value("o_column", o_column, exp_col);
        // result must hold under back-pressure
        hold = $unsigned($random(seed)) % 5;
        repeat (hold) begin
            @(negedge clk);
            check_value("o_valid", o_valid, 1);
            check_value("o_ready", o_ready, 0);
            check_value("o_score", o_score, exp_score);
            check_value("o_row", o_row, exp_row);
            check_value("o_column", o_column, exp_col);
        end
        i_ready = 1'b1;
        @(negedge clk);
        i_ready = 1'b0;
        check_value("o_valid", o_valid, 0);
        check_value("o_ready", o_ready, 1);
        jobs++;
    endtask

    initial begin
        string       line;
        int          fd;
        int          n;
        logic [31:0] v_ref;
        logic [31:0] v_read;
        int          v_ref_len;
        int          v_read_len;
        int          v_score;
        int          v_row;
        int          v_col;
        seed       = 59;
        errors     = 0;
        checks     = 0;
        jobs       = 0;
        aborted    = 1'b0;
        rst        = 1'b1;
        i_valid    = 1'b0;
        i_seq_ref  = '0;
        i_seq_read = '0;
        i_ref_len  = '0;
        i_read_len = '0;
        i_ready    = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("o_valid", o_valid, 0);
        check_value("o_ready", o_ready, 1);

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open %s", STIM_FILE);
        end else begin
            while (!$feof(fd) && !aborted) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line[0] == "#") begin
                    continue;
                end
                n = $sscanf(line, "%h %h %d %d %d %d %d", v_ref, v_read, v_ref_len,
                            v_read_len, v_score, v_row, v_col);
                if (n == 7) begin
                    run_job(v_ref, v_read, v_ref_len, v_read_len, v_score, v_row, v_col);
                end else if (n > 0) begin
                    errors++;
                    $display("Malformed line in %s: %s", STIM_FILE, line);
                end
            end
            $fclose(fd);
        end
        if (jobs == 0) begin
            errors++;
            $display("No job was completed");
        end

        $display("jobs: %0d  checks: %0d  errors: %0d", jobs, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/sw_top.sv ====
`default_nettype none

module sw_top (
    input  logic           clk,
    input  logic           rst,
    // job input
    input  logic           i_valid,
    input  sw_pkg::seq_t   i_seq_ref,
    input  sw_pkg::seq_t   i_seq_read,
    input  sw_pkg::len_t   i_ref_len,
    input  sw_pkg::len_t   i_read_len,
    output logic           o_ready,
    // result output
    input  logic           i_ready,
    output logic           o_valid,
    output sw_pkg::score_t o_score,
    output sw_pkg::idx_t   o_row,
    output sw_pkg::idx_t   o_column
);

    logic result_taken;
    logic loader_done;

    sw_feed_if  feed_if ();
    sw_score_if score_if ();

    // end of calculation enters the array with the feed
    assign feed_if.done = loader_done;

    sw_seq_loader loader_i (
        .clk            (clk),
        .rst            (rst),
        .i_valid        (i_valid),
        .i_seq_ref      (i_seq_ref),
        .i_seq_read     (i_seq_read),
        .i_ref_len      (i_ref_len),
        .i_read_len     (i_read_len),
        .i_result_taken (result_taken),
        .o_ready        (o_ready),
        .feed           (feed_if),
        .o_done         (loader_done)
    );

    sw_cell_array array_i (
        .clk    (clk),
        .rst    (rst),
        .feed   (feed_if),
        .scores (score_if)
    );

    sw_max_tracker tracker_i (
        .clk            (clk),
        .rst            (rst),
        .i_ready        (i_ready),
        .scores         (score_if),
        .o_valid        (o_valid),
        .o_score        (o_score),
        .o_row          (o_row),
        .o_column       (o_column),
        .o_result_taken (result_taken)
    );

endmodule

`default_nettype wire

// ==== src/sw_max_tracker.sv ====
`default_nettype none

module sw_max_tracker (
    input  logic           clk,
    input  logic           rst,
    input  logic           i_ready,
    sw_score_if.sink       scores,
    output logic           o_valid,
    output sw_pkg::score_t o_score,
    output sw_pkg::idx_t   o_row,
    output sw_pkg::idx_t   o_column,
    output logic           o_result_taken
);
    import sw_pkg::*;

    score_t cyc_score;
    idx_t   cyc_col;
    idx_t   cyc_row;
    score_t max_score;
    idx_t   max_row;
    idx_t   max_col;

    // best cell on this anti-diagonal with the lowest column winning a tie
    always_comb begin
        cyc_score = SCORE_MIN;
        cyc_col   = '0;
        for (int j = 0; j < ARRAY_LEN; j++) begin
            if (scores.cell_valid[j] && (scores.cell_score[j] > cyc_score)) begin
                cyc_score = scores.cell_score[j];
                cyc_col   = idx_t'(j);
            end
        end
    end

    assign cyc_row = idx_t'(scores.row_base - len_t'(cyc_col));

    // earlier diagonals keep a tie since only a larger score replaces
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            max_score <= SCORE_MIN;
            max_row   <= '0;
            max_col   <= '0;
        end else if (scores.clear) begin
            max_score <= SCORE_MIN;
            max_row   <= '0;
            max_col   <= '0;
        end else if (cyc_score > max_score) begin
            max_score <= cyc_score;
            max_row   <= cyc_row;
            max_col   <= cyc_col;
        end
    end

    assign o_result_taken = o_valid && i_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else if (scores.done) begin
            o_valid <= 1'b1;
        end else if (o_result_taken) begin
            o_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (scores.done) begin
            o_score  <= max_score;
            o_row    <= max_row;
            o_column <= max_col;
        end
    end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        (o_valid && !i_ready) |=>
            (o_valid && $stable(o_score) && $stable(o_row) && $stable(o_column)));

endmodule

`default_nettype wire

// ==== src/sw_cell_array.sv ====
`default_nettype none

module sw_cell_array (
    input  logic       clk,
    input  logic       rst,
    sw_feed_if.sink    feed,
    sw_score_if.source scores
);
    import sw_pkg::*;

    // read base chain where entry j feeds cell j
    logic [ARRAY_LEN:0] a_valid_c;
    base_t              a_base_c [ARRAY_LEN+1];

    score_t h_c    [ARRAY_LEN];
    score_t e_c    [ARRAY_LEN];
    score_t f_c    [ARRAY_LEN];
    score_t h_q    [ARRAY_LEN];
    score_t e_q    [ARRAY_LEN];
    score_t f_q    [ARRAY_LEN];
    score_t h_qq   [ARRAY_LEN];
    score_t h_left [ARRAY_LEN];
    score_t f_left [ARRAY_LEN];
    score_t h_diag [ARRAY_LEN];
    len_t   row_base;
    logic   done_q;

    assign a_valid_c[0] = feed.a_valid;
    assign a_base_c[0]  = feed.a_base;

    // column 0 sits on the matrix edge
    always_comb begin
        h_left[0] = '0;
        f_left[0] = '0;
        h_diag[0] = '0;
        for (int j = 1; j < ARRAY_LEN; j++) begin
            h_left[j] = h_q[j-1];
            f_left[j] = f_q[j-1];
            h_diag[j] = h_qq[j-1];
        end
    end

    for (genvar j = 0; j < ARRAY_LEN; j++) begin : g_cell
        sw_cell cell_i (
            .clk       (clk),
            .rst       (rst),
            .clear     (feed.clear),
            .i_a_valid (a_valid_c[j]),
            .i_a_base  (a_base_c[j]),
            .i_b_valid (feed.b_valid[j]),
            .i_b_base  (feed.b_bases[SEQ_W-1-BASE_W*j -: BASE_W]),
            .i_h_diag  (h_diag[j]),
            .i_h_top   (h_q[j]),
            .i_e_top   (e_q[j]),
            .i_h_left  (h_left[j]),
            .i_f_left  (f_left[j]),
            .o_h       (h_c[j]),
            .o_e       (e_c[j]),
            .o_f       (f_c[j]),
            .o_a_valid (a_valid_c[j+1]),
            .o_a_base  (a_base_c[j+1])
        );
    end

    // one and two cycle copies of the wavefront
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int j = 0; j < ARRAY_LEN; j++) begin
                h_q[j]  <= '0;
                e_q[j]  <= '0;
                f_q[j]  <= '0;
                h_qq[j] <= '0;
            end
        end else if (feed.clear) begin
            for (int j = 0; j < ARRAY_LEN; j++) begin
                h_q[j]  <= '0;
                e_q[j]  <= '0;
                f_q[j]  <= '0;
                h_qq[j] <= '0;
            end
        end else begin
            h_q  <= h_c;
            e_q  <= e_c;
            f_q  <= f_c;
            h_qq <= h_q;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row_base <= '0;
            done_q   <= 1'b0;
        end else begin
            row_base <= feed.clear ? '0 : row_base + 1'b1;
            done_q   <= feed.done;
        end
    end

    assign scores.cell_score = h_c;
    assign scores.cell_valid = a_valid_c[ARRAY_LEN-1:0] & feed.b_valid;
    assign scores.row_base   = row_base;
    assign scores.clear      = feed.clear;
    assign scores.done       = done_q;

endmodule

`default_nettype wire

// ==== src/sw_cell.sv ====
`default_nettype none

module sw_cell (
    input  logic           clk,
    input  logic           rst,
    input  logic           clear,
    input  logic           i_a_valid,
    input  sw_pkg::base_t  i_a_base,
    input  logic           i_b_valid,
    input  sw_pkg::base_t  i_b_base,
    input  sw_pkg::score_t i_h_diag,
    input  sw_pkg::score_t i_h_top,
    input  sw_pkg::score_t i_e_top,
    input  sw_pkg::score_t i_h_left,
    input  sw_pkg::score_t i_f_left,
    output sw_pkg::score_t o_h,
    output sw_pkg::score_t o_e,
    output sw_pkg::score_t o_f,
    output logic           o_a_valid,
    output sw_pkg::base_t  o_a_base
);
    import sw_pkg::*;

    function automatic score_t smax(input score_t a, input score_t b);
        return (a > b) ? a : b;
    endfunction

    logic   cell_valid;
    score_t diag_sc;
    score_t e_sc;
    score_t f_sc;
    score_t h_sc;

    assign cell_valid = i_a_valid && i_b_valid;

    always_comb begin
        if (i_a_base == i_b_base) begin
            diag_sc = i_h_diag + MATCH_SCORE;
        end else begin
            diag_sc = i_h_diag + MISMATCH_SCORE;
        end
        // vertical gap from the row above
        e_sc = smax('0, smax(i_h_top + GAP_OPEN, i_e_top + GAP_EXTEND));
        // horizontal gap from the column to the left
        f_sc = smax('0, smax(i_h_left + GAP_OPEN, i_f_left + GAP_EXTEND));
        h_sc = smax(smax('0, diag_sc), smax(e_sc, f_sc));
    end

    // unused positions report zero so they never win
    assign o_h = cell_valid ? h_sc : '0;
    assign o_e = cell_valid ? e_sc : '0;
    assign o_f = cell_valid ? f_sc : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_a_valid <= 1'b0;
        end else if (clear) begin
            o_a_valid <= 1'b0;
        end else begin
            o_a_valid <= i_a_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_a_base <= i_a_base;
    end

endmodule

`default_nettype wire

// ==== src/sw_seq_loader.sv ====
`default_nettype none

module sw_seq_loader (
    input  logic         clk,
    input  logic         rst,
    input  logic         i_valid,
    input  sw_pkg::seq_t i_seq_ref,
    input  sw_pkg::seq_t i_seq_read,
    input  sw_pkg::len_t i_ref_len,
    input  sw_pkg::len_t i_read_len,
    input  logic         i_result_taken,
    output logic         o_ready,
    sw_feed_if.source    feed,
    output logic         o_done
);
    import sw_pkg::*;

    logic [1:0]           state;
    seq_t                 ref_q;
    seq_t                 read_sh;
    len_t                 ref_len_q;
    len_t                 read_len_q;
    len_t                 cnt;
    logic                 clear_q;
    logic [ARRAY_LEN-1:0] b_mask;
    logic [ARRAY_LEN-1:0] ref_mask;
    logic [LEN_W:0]       len_sum;
    logic                 accept;
    logic                 calc_last;

    assign accept = (state == ST_IDLE) && i_valid;

    // calculate runs read_len + ref_len - 1 cycles with cnt from 0
    assign len_sum   = {1'b0, ref_len_q} + {1'b0, read_len_q};
    assign calc_last = (({1'b0, cnt} + (LEN_W + 1)'(2)) == len_sum);

    // columns below the reference length
    always_comb begin
        for (int j = 0; j < ARRAY_LEN; j++) begin
            ref_mask[j] = (LEN_W'(j) < i_ref_len);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            cnt        <= '0;
            clear_q    <= 1'b0;
            o_done     <= 1'b0;
            ref_len_q  <= '0;
            read_len_q <= '0;
            b_mask     <= '0;
        end else begin
            clear_q <= accept;
            o_done  <= (state == ST_CALC) && calc_last;
            case (state)
                ST_IDLE: begin
                    if (i_valid) begin
                        state      <= ST_LOAD;
                        ref_len_q  <= i_ref_len;
                        read_len_q <= i_read_len;
                        b_mask     <= ref_mask;
                    end
                end
                ST_LOAD: begin
                    state <= ST_CALC;
                    cnt   <= '0;
                end
                ST_CALC: begin
                    if (calc_last) begin
                        state <= ST_WAIT;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    // hold until the tracker hands the result off
                    if (i_result_taken) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // read side shifts one base per calculate cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            ref_q   <= i_seq_ref;
            read_sh <= i_seq_read;
        end else if (state == ST_CALC) begin
            read_sh <= read_sh << BASE_W;
        end
    end

    assign o_ready      = (state == ST_IDLE);
    assign feed.a_base  = read_sh[SEQ_W-1 -: BASE_W];
    assign feed.a_valid = (state == ST_CALC) && (cnt < read_len_q);
    assign feed.b_bases = ref_q;
    assign feed.b_valid = b_mask;
    assign feed.clear   = clear_q;

    a_len_range: assert property (@(posedge clk) disable iff (rst)
        accept |-> (i_ref_len inside {[1:ARRAY_LEN]}) && (i_read_len inside {[1:ARRAY_LEN]}));

endmodule

`default_nettype wire

// ==== src/sw_score_if.sv ====
`default_nettype none

interface sw_score_if;
    import sw_pkg::*;

    // H of every cell for the current anti-diagonal
    score_t               cell_score [ARRAY_LEN];
    // a-valid and b-valid of each cell
    logic [ARRAY_LEN-1:0] cell_valid;
    // read index at cell 0
    // cell j works on row row_base minus j
    len_t                 row_base;
    logic                 clear;
    logic                 done;

    modport source (output cell_score, cell_valid, row_base, clear, done);

    modport sink (input cell_score, cell_valid, row_base, clear, done);

endinterface

`default_nettype wire

// ==== src/sw_feed_if.sv ====
`default_nettype none

interface sw_feed_if;
    import sw_pkg::*;

    // read base entering cell 0
    base_t                a_base;
    logic                 a_valid;
    // whole reference with one base per column
    seq_t                 b_bases;
    logic [ARRAY_LEN-1:0] b_valid;
    // zeroes the score registers at load time
    logic                 clear;
    // end of calculation wired in at the top level
    logic                 done;

    modport source (output a_base, a_valid, b_bases, b_valid, clear);

    modport sink (input a_base, a_valid, b_bases, b_valid, clear, done);

endinterface

`default_nettype wire

// ==== src/sw_pkg.sv ====
`default_nettype none

package sw_pkg;

    // array and field sizes
    localparam int ARRAY_LEN = 16;
    localparam int BASE_W    = 2;
    localparam int SEQ_W     = ARRAY_LEN * BASE_W;
    localparam int LEN_W     = 5;
    localparam int IDX_W     = 4;
    localparam int SCORE_W   = 10;

    typedef logic        [BASE_W-1:0]  base_t;
    typedef logic signed [SCORE_W-1:0] score_t;
    typedef logic        [IDX_W-1:0]   idx_t;
    typedef logic        [LEN_W-1:0]   len_t;
    // base 0 in the top pair
    typedef logic        [SEQ_W-1:0]   seq_t;

    // affine gap scoring
    localparam score_t MATCH_SCORE    = 10'sd1;
    localparam score_t MISMATCH_SCORE = -10'sd4;
    localparam score_t GAP_OPEN       = -10'sd6;
    localparam score_t GAP_EXTEND     = -10'sd1;
    localparam score_t SCORE_MIN      = {1'b1, {(SCORE_W - 1){1'b0}}};

    // loader FSM encoding
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_LOAD = 2'd1;
    localparam logic [1:0] ST_CALC = 2'd2;
    localparam logic [1:0] ST_WAIT = 2'd3;

endpackage

`default_nettype wire
